// File: verilog.f
common/portalPkg.sv
common/portalReqIf.sv
common/portalDataIf.sv
hw/portalFifo.sv
axiBridge/axiWriteBridge.sv
axiBridge/axiReadBridge.sv
hw/portalMemory.sv
hw/zynqPortalTop.sv
bench/portal_checker.sv
bench/portalTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module portalTb

status=0
output=$(./obj_dir/VportalTb 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -qx 'test passed'; then
  exit 0
fi
exit 1

// File: bench/portalTb.sv
`timescale 1ns/1ns

module portalTb
  import portalPkg::*;
();

  localparam int MemWords = 64;
  localparam int IdxWidth = $clog2(MemWords);
  localparam int ClkPeriod = 4;
  // Fill, single beats, random bursts, bursts with gaps, wrap
  localparam int TxnCount = MemWords / 16 + 2 * 4 + 2 * 12 + 2 * 12 + 3;
  localparam int CyclesPerTxn = 40 * 16;
  localparam axiRespT Okay = 2'b00;

  logic clk;
  logic rstN;
  logic awValid;
  logic awReady;
  logic [DataWidth-1:0] awAddr;
  axiLenT awLen;
  logic [AxiIdWidth-1:0] awId;
  logic wValid;
  logic wReady;
  wordT wData;
  logic [AxiIdWidth-1:0] wId;
  logic wLast;
  logic bValid;
  logic bReady;
  logic [AxiIdWidth-1:0] bId;
  axiRespT bResp;
  logic arValid;
  logic arReady;
  logic [DataWidth-1:0] arAddr;
  axiLenT arLen;
  logic [AxiIdWidth-1:0] arId;
  logic rValid;
  logic rReady;
  wordT rData;
  logic [AxiIdWidth-1:0] rId;
  logic rLast;
  axiRespT rResp;

  wordT mirror [MemWords];
  int seed;
  int writesDone;
  int readsDone;
  int beatIdx;
  logic gapsOn;
  portalIdT bIdQ [$];
  logic [DataWidth-1:0] rdAddrQ [$];
  axiLenT rdLenQ [$];
  portalIdT rdIdQ [$];

  zynqPortalTop #(.MemWords(MemWords)) dut_i (
    .clk(clk), .rstN(rstN),
    .awValid(awValid), .awReady(awReady), .awAddr(awAddr), .awLen(awLen), .awId(awId),
    .wValid(wValid), .wReady(wReady), .wData(wData), .wId(wId), .wLast(wLast),
    .bValid(bValid), .bReady(bReady), .bId(bId), .bResp(bResp),
    .arValid(arValid), .arReady(arReady), .arAddr(arAddr), .arLen(arLen), .arId(arId),
    .rValid(rValid), .rReady(rReady), .rData(rData), .rId(rId), .rLast(rLast),
    .rResp(rResp)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Word index wraps modulo the memory size
  function automatic logic [IdxWidth-1:0] wordIndex(logic [DataWidth-1:0] addr);
    return IdxWidth'((addr / BytesPerWord) % MemWords);
  endfunction

  function automatic wordT expectWord(logic [DataWidth-1:0] addr);
    return mirror[wordIndex(addr)];
  endfunction

  function automatic logic [DataWidth-1:0] randomAddr();
    return $random(seed) & 32'hFFFF_FFFC;
  endfunction

  function automatic logic [AxiIdWidth-1:0] randomId();
    return AxiIdWidth'($random(seed));
  endfunction

  task automatic stopRun(string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic checkWord(string name, wordT got, wordT exp);
    if (got !== exp) begin
      stopRun($sformatf("ERROR %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkId(string name, portalIdT got, portalIdT exp);
    if (got !== exp) begin
      stopRun($sformatf("ERROR %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkResp(string name, axiRespT got, axiRespT exp);
    if (got !== exp) begin
      stopRun($sformatf("ERROR %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic checkLast(string name, logic got, logic exp);
    if (got !== exp) begin
      stopRun($sformatf("ERROR %s got %h expected %h", name, got, exp));
    end
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic writeBurst(logic [DataWidth-1:0] addr, axiLenT len,
                            logic [AxiIdWidth-1:0] id);
    int target;
    wordT word;
    target = writesDone + 1;
    bIdQ.push_back(id[PortalIdWidth-1:0]);
    awAddr = addr;
    awLen = len;
    awId = id;
    awValid = 1'b1;
    @(posedge clk);
    while (!awReady) @(posedge clk);
    #1;
    awValid = 1'b0;
    for (int k = 0; k <= int'(len); k++) begin
      word = $random(seed);
      wData = word;
      wId = id;
      wLast = (k == int'(len));
      wValid = 1'b1;
      @(posedge clk);
      while (!wReady) @(posedge clk);
      #1;
      mirror[wordIndex(addr + 32'(4 * k))] = word;
    end
    wValid = 1'b0;
    wLast = 1'b0;
    while (writesDone < target) @(posedge clk);
    #1;
  endtask

  task automatic readBurst(logic [DataWidth-1:0] addr, axiLenT len,
                           logic [AxiIdWidth-1:0] id);
    int target;
    target = readsDone + 1;
    rdAddrQ.push_back(addr);
    rdLenQ.push_back(len);
    rdIdQ.push_back(id[PortalIdWidth-1:0]);
    arAddr = addr;
    arLen = len;
    arId = id;
    arValid = 1'b1;
    @(posedge clk);
    while (!arReady) @(posedge clk);
    #1;
    arValid = 0;
    while (readsDone < target) @(posedge clk);
    #1;
  endtask

  // Response ready, with random gaps once enabled
  initial begin
    forever begin
      @(posedge clk);
      #1;
      if (gapsOn) begin
        bReady = (($random(seed) & 3) != 0);
        rReady = (($random(seed) & 3) != 0);
      end else begin
        bReady = 1'b1;
        rReady = 1'b1;
      end
    end
  end

  // Compare at every B and R handshake
  initial begin
    forever begin
      @(posedge clk);
      if (rstN && bValid && bReady) begin
        if (bIdQ.size() == 0) begin
          stopRun("write response arrived with no write outstanding");
        end else begin
          checkId("bId", portalIdT'(bId), bIdQ.pop_front());
          checkId("bId upper bits", portalIdT'(bId >> PortalIdWidth), '0);
          checkResp("bResp", bResp, Okay);
          writesDone++;
        end
      end
      if (rstN && rValid && rReady) begin
        if (rdAddrQ.size() == 0) begin
          stopRun("read data arrived with no read outstanding");
        end else begin
          checkWord("rData", rData, expectWord(rdAddrQ[0] + 32'(4 * beatIdx)));
          checkId("rId", portalIdT'(rId), rdIdQ[0]);
          checkId("rId upper bits", portalIdT'(rId >> PortalIdWidth), '0);
          checkResp("rResp", rResp, Okay);
          checkLast("rLast", rLast, beatIdx == int'(rdLenQ[0]));
          if (rLast) begin
            void'(rdAddrQ.pop_front());
            void'(rdLenQ.pop_front());
            void'(rdIdQ.pop_front());
            beatIdx = 0;
            readsDone++;
          end else begin
            beatIdx++;
          end
        end
      end
    end
  end

  initial begin
    repeat (TxnCount * CyclesPerTxn) @(posedge clk);
    stopRun("TIMEOUT watchdog expired before all transactions finished");
  end

  initial begin
    logic [DataWidth-1:0] addr;
    axiLenT len;
    seed = 32'h4b8c583e;
    writesDone = 0;
    readsDone = 0;
    beatIdx = 0;
    gapsOn = 1'b0;
    rstN = 1'b0;
    awValid = 1'b0;
    awAddr = '0;
    awLen = '0;
    awId = '0;
    wValid = 1'b0;
    wData = '0;
    wId = '0;
    wLast = 1'b0;
    bReady = 1'b1;
    arValid = 1'b0;
    arAddr = '0;
    arLen = '0;
    arId = '0;
    rReady = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rstN = 1'b1;
    @(posedge clk);
    checkLast("bValid", bValid, 1'b0);
    checkLast("rValid", rValid, 1'b0);
    #1;
    // Fill the whole memory first
    for (int i = 0; i < MemWords / 16; i++) begin
      writeBurst(32'(i * 64), 4'hF, randomId());
    end
    for (int i = 0; i < 4; i++) begin
      addr = randomAddr();
      writeBurst(addr, 4'h0, randomId());
      readBurst(addr, 4'h0, randomId());
    end
    for (int i = 0; i < 12; i++) begin
      addr = randomAddr();
      len = axiLenT'($random(seed));
      writeBurst(addr, len, randomId());
      readBurst(addr, len, randomId());
    end
    gapsOn = 1'b1;
    for (int i = 0; i < 12; i++) begin
      addr = randomAddr();
      len = axiLenT'($random(seed));
      writeBurst(addr, len, randomId());
      readBurst(addr, len, randomId());
    end
    // Burst across the end of memory, then an aliased read
    addr = 32'((MemWords - 3) * 4);
    writeBurst(addr, 4'h7, randomId());
    readBurst(addr, 4'h7, randomId());
    readBurst(addr + 32'(MemWords * 4 * 5), 4'h7, randomId());
    $display("test passed");
    $finish;
  end

endmodule

// File: bench/portal_checker.sv
`timescale 1ns/1ns

module portalChecker
  import portalPkg::*;
(
  input logic                  clk,
  input logic                  rstN,
  input logic                  bValid,
  input logic                  bReady,
  input logic [AxiIdWidth-1:0] bId,
  input logic                  rValid,
  input logic                  rReady,
  input wordT                  rData,
  input logic [AxiIdWidth-1:0] rId,
  input logic                  rLast,
  input axiRespT               rResp
);

  // R channel holds while the master stalls
  rHold: assert property (@(posedge clk) disable iff (!rstN)
    rValid && !rReady |=> rValid && $stable({rData, rId, rLast, rResp}))
    else $error("R channel changed while RREADY was low");

  bHold: assert property (@(posedge clk) disable iff (!rstN)
    bValid && !bReady |=> bValid && $stable(bId))
    else $error("B channel changed while BREADY was low");

  resetIdle: assert property (@(posedge clk) $rose(rstN) |-> !bValid && !rValid)
    else $error("response valid high right after reset");

endmodule

bind zynqPortalTop portalChecker checker_i (
  .clk(clk),
  .rstN(rstN),
  .bValid(bValid),
  .bReady(bReady),
  .bId(bId),
  .rValid(rValid),
  .rReady(rReady),
  .rData(rData),
  .rId(rId),
  .rLast(rLast),
  .rResp(rResp)
);

// File: hw/zynqPortalTop.sv
`timescale 1ns/1ns

module zynqPortalTop
  import portalPkg::*;
#(
  parameter int MemWords = 64
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  awValid,
  output logic                  awReady,
  input  logic [DataWidth-1:0]  awAddr,
  input  axiLenT                awLen,
  input  logic [AxiIdWidth-1:0] awId,
  input  logic                  wValid,
  output logic                  wReady,
  input  wordT                  wData,
  input  logic [AxiIdWidth-1:0] wId,
  input  logic                  wLast,
  output logic                  bValid,
  input  logic                  bReady,
  output logic [AxiIdWidth-1:0] bId,
  output axiRespT               bResp,
  input  logic                  arValid,
  output logic                  arReady,
  input  logic [DataWidth-1:0]  arAddr,
  input  axiLenT                arLen,
  input  logic [AxiIdWidth-1:0] arId,
  output logic                  rValid,
  input  logic                  rReady,
  output wordT                  rData,
  output logic [AxiIdWidth-1:0] rId,
  output logic                  rLast,
  output axiRespT               rResp
);

  portalReqIf writeReq ();
  portalDataIf writeData ();
  portalReqIf readReq ();
  portalDataIf readData ();

  logic doneValid;
  logic doneReady;
  portalIdT doneId;

  axiWriteBridge writeBridge_i (
    .clk(clk), .rstN(rstN),
    .awValid(awValid), .awReady(awReady), .awAddr(awAddr), .awLen(awLen), .awId(awId),
    .wValid(wValid), .wReady(wReady), .wData(wData), .wId(wId), .wLast(wLast),
    .bValid(bValid), .bReady(bReady), .bId(bId), .bResp(bResp),
    .req(writeReq.source),
    .data(writeData.source),
    .doneValid(doneValid), .doneReady(doneReady), .doneId(doneId)
  );

  axiReadBridge readBridge_i (
    .clk(clk), .rstN(rstN),
    .arValid(arValid), .arReady(arReady), .arAddr(arAddr), .arLen(arLen), .arId(arId),
    .rValid(rValid), .rReady(rReady), .rData(rData), .rId(rId), .rLast(rLast),
    .rResp(rResp),
    .req(readReq.source),
    .data(readData.sink)
  );

  portalMemory #(.MemWords(MemWords)) memory_i (
    .clk(clk),
    .rstN(rstN),
    .writeReq(writeReq.sink),
    .writeData(writeData.sink),
    .doneValid(doneValid),
    .doneReady(doneReady),
    .doneId(doneId),
    .readReq(readReq.sink),
    .readData(readData.source)
  );

endmodule

// File: hw/portalMemory.sv
`timescale 1ns/1ns

module portalMemory
  import portalPkg::*;
#(
  parameter int MemWords = 64
) (
  input  logic        clk,
  input  logic        rstN,
  portalReqIf.sink    writeReq,
  portalDataIf.sink   writeData,
  output logic        doneValid,
  input  logic        doneReady,
  output portalIdT    doneId,
  portalReqIf.sink    readReq,
  portalDataIf.source readData
);

  localparam int IdxWidth = $clog2(MemWords);
  localparam int BeatWidth = ByteCountWidth - 2;

  wordT mem [MemWords];

  logic wrBusy;
  logic [IdxWidth-1:0] wrIndex;
  logic [BeatWidth-1:0] wrLeft;
  portalIdT wrId;
  logic wrAccept;
  logic wrFire;

  logic rdBusy;
  logic [IdxWidth-1:0] rdIndex;
  logic [BeatWidth-1:0] rdLeft;
  portalIdT rdId;
  logic rdAccept;
  logic rdFire;

  // Write side stays closed until its done has been taken
  assign writeReq.ready = !wrBusy && !doneValid;
  assign writeData.ready = wrBusy;
  assign wrAccept = writeReq.valid && writeReq.ready;
  assign wrFire = writeData.valid && writeData.ready;
  assign doneId = wrId;

  assign readReq.ready = !rdBusy;
  assign readData.valid = rdBusy;
  assign rdAccept = readReq.valid && readReq.ready;
  assign rdFire = readData.valid && readData.ready;
  assign readData.beat = '{data: mem[rdIndex], id: rdId, last: (rdLeft == BeatWidth'(1))};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrBusy <= 1'b0;
      wrLeft <= '0;
      doneValid <= 1'b0;
    end else begin
      if (wrAccept) begin
        wrBusy <= 1'b1;
        wrLeft <= writeReq.req.byteCount[ByteCountWidth-1:2];
      end else if (wrFire) begin
        wrLeft <= wrLeft - BeatWidth'(1);
        if (wrLeft == BeatWidth'(1)) begin
          wrBusy <= 1'b0;
          doneValid <= 1'b1;
        end
      end
      if (doneValid && doneReady) begin
        doneValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rdBusy <= 1'b0;
      rdLeft <= '0;
    end else begin
      if (rdAccept) begin
        rdBusy <= 1'b1;
        rdLeft <= readReq.req.byteCount[ByteCountWidth-1:2];
      end else if (rdFire) begin
        rdLeft <= rdLeft - BeatWidth'(1);
        if (rdLeft == BeatWidth'(1)) begin
          rdBusy <= 1'b0;
        end
      end
    end
  end

  // Word index is the byte address over four, wrapping at MemWords
  always_ff @(posedge clk) begin
    if (wrAccept) begin
      wrIndex <= writeReq.req.addr[IdxWidth+1:2];
      wrId <= writeReq.req.id;
    end else if (wrFire) begin
      mem[wrIndex] <= writeData.beat.data;
      wrIndex <= wrIndex + IdxWidth'(1);
    end
    if (rdAccept) begin
      rdIndex <= readReq.req.addr[IdxWidth+1:2];
      rdId <= readReq.req.id;
    end else if (rdFire) begin
      rdIndex <= rdIndex + IdxWidth'(1);
    end
  end

endmodule

// File: axiBridge/axiReadBridge.sv
`timescale 1ns/1ns

module axiReadBridge
  import portalPkg::*;
(
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  arValid,
  output logic                  arReady,
  input  logic [DataWidth-1:0]  arAddr,
  input  axiLenT                arLen,
  input  logic [AxiIdWidth-1:0] arId,
  output logic                  rValid,
  input  logic                  rReady,
  output wordT                  rData,
  output logic [AxiIdWidth-1:0] rId,
  output logic                  rLast,
  output axiRespT               rResp,
  portalReqIf.source            req,
  portalDataIf.sink             data
);

  logic arFull;
  logic rFull;
  portalBeatT rBeat;

  assign arReady = !arFull;
  // Memory stalls while the beat buffer is full
  assign data.ready = !rFull;

  portalFifo #(.payloadT(portalReqT)) arFifo_i (
    .clk(clk),
    .rstN(rstN),
    .push(arValid && arReady),
    .pushData(makeReq(arAddr, arLen, arId)),
    .full(arFull),
    .pop(req.valid && req.ready),
    .popData(req.req),
    .notEmpty(req.valid)
  );

  portalFifo #(.payloadT(portalBeatT)) rFifo_i (
    .clk(clk),
    .rstN(rstN),
    .push(data.valid && data.ready),
    .pushData(data.beat),
    .full(rFull),
    .pop(rValid && rReady),
    .popData(rBeat),
    .notEmpty(rValid)
  );

  assign rData = rBeat.data;
  assign rId = AxiIdWidth'(rBeat.id);
  assign rLast = rBeat.last;
  assign rResp = RespOkay;

endmodule

// File: axiBridge/axiWriteBridge.sv
`timescale 1ns/1ns

module axiWriteBridge
  import portalPkg::*;
(
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  awValid,
  output logic                  awReady,
  input  logic [DataWidth-1:0]  awAddr,
  input  axiLenT                awLen,
  input  logic [AxiIdWidth-1:0] awId,
  input  logic                  wValid,
  output logic                  wReady,
  input  wordT                  wData,
  input  logic [AxiIdWidth-1:0] wId,
  input  logic                  wLast,
  output logic                  bValid,
  input  logic                  bReady,
  output logic [AxiIdWidth-1:0] bId,
  output axiRespT               bResp,
  portalReqIf.source            req,
  portalDataIf.source           data,
  input  logic                  doneValid,
  output logic                  doneReady,
  input  portalIdT              doneId
);

  logic awFull;
  logic wFull;
  logic doneFull;
  portalIdT bIdShort;
  portalBeatT wBeat;

  assign awReady = !awFull;
  assign wReady = !wFull;
  assign doneReady = !doneFull;

  assign wBeat.data = wData;
  assign wBeat.id = wId[PortalIdWidth-1:0];
  assign wBeat.last = wLast;

  portalFifo #(.payloadT(portalReqT)) awFifo_i (
    .clk(clk),
    .rstN(rstN),
    .push(awValid && awReady),
    .pushData(makeReq(awAddr, awLen, awId)),
    .full(awFull),
    .pop(req.valid && req.ready),
    .popData(req.req),
    .notEmpty(req.valid)
  );

  portalFifo #(.payloadT(portalBeatT)) wFifo_i (
    .clk(clk),
    .rstN(rstN),
    .push(wValid && wReady),
    .pushData(wBeat),
    .full(wFull),
    .pop(data.valid && data.ready),
    .popData(data.beat),
    .notEmpty(data.valid)
  );

  // Done IDs wait here until the master takes the response
  portalFifo #(.payloadT(portalIdT)) bFifo_i (
    .clk(clk),
    .rstN(rstN),
    .push(doneValid && doneReady),
    .pushData(doneId),
    .full(doneFull),
    .pop(bValid && bReady),
    .popData(bIdShort),
    .notEmpty(bValid)
  );

  assign bId = AxiIdWidth'(bIdShort);
  assign bResp = RespOkay;

endmodule

// File: hw/portalFifo.sv
`timescale 1ns/1ns

module portalFifo #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    push,
  input  payloadT pushData,
  output logic    full,
  input  logic    pop,
  output payloadT popData,
  output logic    notEmpty
);

  payloadT entries [2];
  logic rdPtr;
  logic [1:0] count;
  logic wrPtr;
  logic doPush;
  logic doPop;

  assign full = (count == 2'd2);
  assign notEmpty = (count != 2'd0);
  assign doPop = pop && notEmpty;
  // Full only takes a push when the head leaves in the same cycle
  assign doPush = push && (!full || doPop);
  assign wrPtr = rdPtr ^ count[0];
  assign popData = entries[rdPtr];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rdPtr <= 1'b0;
      count <= 2'd0;
    end else begin
      if (doPop) begin
        rdPtr <= ~rdPtr;
      end
      case ({doPush, doPop})
        2'b10: count <= count + 2'd1;
        2'b01: count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (doPush) begin
      entries[wrPtr] <= pushData;
    end
  end

endmodule

// File: common/portalDataIf.sv
`timescale 1ns/1ns

// Beat channel, used for write and read data
interface portalDataIf
  import portalPkg::*;
();

  logic valid;
  logic ready;
  portalBeatT beat;

  modport source (
    output valid,
    output beat,
    input  ready
  );

  modport sink (
    input  valid,
    input  beat,
    output ready
  );

endinterface

// File: common/portalReqIf.sv
`timescale 1ns/1ns

// Split-transaction request channel
interface portalReqIf
  import portalPkg::*;
();

  logic valid;
  logic ready;
  portalReqT req;

  modport source (
    output valid,
    output req,
    input  ready
  );

  modport sink (
    input  valid,
    input  req,
    output ready
  );

endinterface

// File: common/portalPkg.sv
package portalPkg;

  localparam int DataWidth = 32;
  localparam int AxiIdWidth = 12;
  localparam int PortalIdWidth = 6;
  localparam int PortalAddrWidth = 18;
  localparam int ByteCountWidth = 10;
  localparam int BytesPerWord = 4;

  typedef logic [DataWidth-1:0] wordT;
  typedef logic [PortalIdWidth-1:0] portalIdT;
  typedef logic [PortalAddrWidth-1:0] portalAddrT;
  typedef logic [ByteCountWidth-1:0] byteCountT;
  typedef logic [3:0] axiLenT;
  typedef logic [1:0] axiRespT;

  // Address, byte count and ID, 34 bits
  typedef struct packed {
    portalAddrT addr;
    byteCountT byteCount;
    portalIdT id;
  } portalReqT;

  // One data beat, 39 bits
  typedef struct packed {
    wordT data;
    portalIdT id;
    logic last;
  } portalBeatT;

  localparam axiRespT RespOkay = 2'b00;

  // AXI3 length field counts beats minus one
  function automatic portalReqT makeReq(logic [DataWidth-1:0] addr, axiLenT len,
                                        logic [AxiIdWidth-1:0] id);
    portalReqT req;
    req.addr = addr[PortalAddrWidth-1:0];
    req.byteCount = byteCountT'((byteCountT'(len) + byteCountT'(1)) * BytesPerWord);
    req.id = id[PortalIdWidth-1:0];
    return req;
  endfunction

endpackage
